// File: files.f
dcache_pkg.sv
main_cache.sv
victim_cache.sv
miss_control.sv
writeback_buffer.sv
mem_arbiter.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - main_cache.sv
  - victim_cache.sv
  - miss_control.sv
  - writeback_buffer.sv
  - mem_arbiter.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_dcache.sv

// File: tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

    logic clock;
    logic reset;
    logic req_valid;
    mem_op_t req_op;
    logic [addr_width-1:0] req_addr;
    mem_size_t req_size;
    logic [31:0] req_wdata;
    logic stall;
    logic resp_valid;
    mem_op_t resp_op;
    logic [31:0] resp_rdata;
    bus_cmd_t mem_cmd;
    logic [addr_width-1:0] mem_addr;
    block_t mem_wdata;
    logic [mem_tag_bits-1:0] mem_accept_tag;
    logic [mem_tag_bits-1:0] mem_resp_tag;
    block_t mem_rdata;

    logic refuse;
    logic [1:0] delay;
    block_t expect_line;
    logic store_error;

    // byte image of what memory should hold after every finished store
    logic [7:0] shadow [4096];
    logic [31:0] lfsr_state;
    int unsigned stores_seen = 0;
    int unsigned loads_seen = 0;

    dcache_top i_dut (.*);

    tb_mem_model i_mem (.*);

    initial clock = 1'b0;
    always #2 clock = ~clock;

    // line under the bus address as the shadow sees it
    for (genvar b = 0; b < 8; b++) begin : g_expect
        assign expect_line[8*b +: 8] = shadow[{mem_addr[11:3], 3'(b)}];
    end

    // galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    // one step per bit
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic mem_size_t random_size();
        logic [1:0] s;
        s = 2'(random_bits(2));
        return (s == 2'd3) ? size_word : mem_size_t'(s);
    endfunction

    // naturally aligned address in the low 1 KB
    function automatic logic [11:0] random_addr(mem_size_t size);
        logic [11:0] a;
        a = {2'b00, 10'(random_bits(10))};
        if (size == size_half) a[0] = 1'b0;
        if (size == size_word) a[1:0] = 2'b00;
        return a;
    endfunction

    // index 9 with tags above the random window
    function automatic logic [11:0] same_index_addr(int tag);
        return {4'(tag), 5'd9, 3'd0};
    endfunction

    // little-endian lanes with zero extension
    function automatic logic [31:0] expected_read(logic [11:0] addr, mem_size_t size);
        case (size)
            size_byte: return {24'b0, shadow[addr]};
            size_half: return {16'b0, shadow[addr + 12'd1], shadow[addr]};
            default: return {shadow[addr + 12'd3], shadow[addr + 12'd2],
                             shadow[addr + 12'd1], shadow[addr]};
        endcase
    endfunction

    task automatic write_shadow(input logic [11:0] addr, input mem_size_t size,
                                input logic [31:0] data);
        shadow[addr] = data[7:0];
        if (size != size_byte) shadow[addr + 12'd1] = data[15:8];
        if (size == size_word) begin
            shadow[addr + 12'd2] = data[23:16];
            shadow[addr + 12'd3] = data[31:24];
        end
    endtask

    task automatic stop_on_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        stop_on_failure();
    endtask

    task automatic check_response(input mem_op_t op, input logic [11:0] addr,
                                  input logic [31:0] expected);
        assert (resp_op == op) else mismatch($sformatf("wrong response op for %h", addr));
        if (op == op_read) begin
            assert (resp_rdata == expected) else
                mismatch($sformatf("load %h gave %h, expected %h", addr, resp_rdata, expected));
        end else begin
            assert (resp_rdata == '0) else mismatch($sformatf("store %h returned data", addr));
        end
    endtask

    task automatic idle_check(input int cycles, input logic bus_quiet);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clock);
            req_valid = 1'b0;
            #1;
            assert (!resp_valid && !stall) else mismatch("response or stall with no request");
            if (bus_quiet) begin
                assert (mem_cmd == bus_none) else mismatch("bus command before any request");
            end
        end
    endtask

    // one request, hit or miss, through to its response
    task automatic access(input mem_op_t op, input logic [11:0] addr, input mem_size_t size,
                          input logic [31:0] data, input logic must_hit);
        logic [31:0] expected;
        int cycles;
        @(negedge clock);
        req_valid = 1'b1;
        req_op = op;
        req_addr = {20'b0, addr};
        req_size = size;
        req_wdata = data;
        expected = expected_read(addr, size);
        #1;
        if (resp_valid) begin
            assert (!stall) else mismatch("stall high during a hit");
            check_response(op, addr, expected);
        end else begin
            assert (!must_hit) else mismatch($sformatf("no same-cycle hit for %h", addr));
            @(negedge clock);
            req_valid = 1'b0;
            #1;
            cycles = 0;
            while (!resp_valid) begin
                assert (stall) else mismatch($sformatf("stall low while %h misses", addr));
                if (cycles == 200) begin
                    $display("Timed out waiting for the miss on %h to finish", addr);
                    stop_on_failure();
                end
                cycles++;
                @(negedge clock);
                #1;
            end
            // stall holds through the response cycle and then drops
            assert (stall) else mismatch("stall already low in the response cycle");
            check_response(op, addr, expected);
            @(negedge clock);
            #1;
            assert (!stall && !resp_valid) else mismatch("stall or response after the miss");
        end
        if (op == op_write) write_shadow(addr, size, data);
    endtask

    // refusals and load latency for the memory model
    always @(posedge clock) begin
        refuse <= (random_bits(2) == 32'd0);
        delay <= 2'(random_bits(2));
    end

    // accepted bus commands by kind
    always @(posedge clock) begin
        if (!reset && mem_accept_tag != '0 && mem_cmd == bus_store) stores_seen++;
        if (!reset && mem_accept_tag != '0 && mem_cmd == bus_load) loads_seen++;
    end

    always @(negedge clock) begin
        if (store_error) stop_on_failure();
    end

    initial begin
        logic [11:0] stored_addrs[$];
        mem_size_t stored_sizes[$];
        logic [11:0] addr;
        mem_size_t size;
        int unsigned wb_before;
        int unsigned loads_before;
        lfsr_state = 32'ha41e;
        reset = 1'b1;
        req_valid = 1'b0;
        req_op = op_read;
        req_addr = '0;
        req_size = size_byte;
        req_wdata = '0;
        refuse = 1'b0;
        delay = 2'd0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int i = 0; i < 4096; i++) shadow[i] = i_mem.backing[i];
        idle_check(4, 1'b1);

        // stores of every size, then read each one back
        for (int i = 0; i < 48; i++) begin
            size = random_size();
            addr = random_addr(size);
            access(op_write, addr, size, random_bits(32), 1'b0);
            stored_addrs.push_back(addr);
            stored_sizes.push_back(size);
        end
        foreach (stored_addrs[i]) access(op_read, stored_addrs[i], stored_sizes[i], '0, 1'b0);
        for (int i = 0; i < 80; i++) begin
            size = random_size();
            addr = random_addr(size);
            access(mem_op_t'(random_bits(1)), addr, size, random_bits(32), 1'b0);
        end

        // four dirty lines on one index, three end up in the victim cache
        for (int t = 8; t < 12; t++) access(op_write, same_index_addr(t), size_word,
                                            random_bits(32), 1'b0);
        loads_before = loads_seen;
        for (int t = 8; t < 12; t++) access(op_read, same_index_addr(t), size_word, '0, 1'b1);
        assert (loads_seen == loads_before) else mismatch("load on the bus during victim hits");

        // overflow the victim cache, then reload everything
        wb_before = stores_seen;
        for (int t = 12; t < 16; t++) access(op_write, same_index_addr(t), size_word,
                                             random_bits(32), 1'b0);
        for (int t = 8; t < 16; t++) access(op_read, same_index_addr(t), size_word, '0, 1'b0);
        assert (stores_seen > wb_before) else mismatch("no write-back after victim overflow");

        idle_check(4, 1'b0);
        $display("All checks passed");
        $finish;
    end

endmodule

// File: tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model import dcache_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  bus_cmd_t mem_cmd,
    input  logic [addr_width-1:0] mem_addr,
    input  block_t mem_wdata,
    output logic [mem_tag_bits-1:0] mem_accept_tag,
    output logic [mem_tag_bits-1:0] mem_resp_tag,
    output block_t mem_rdata,
    // refusal and latency picks from the testbench LFSR
    input  logic refuse,
    input  logic [1:0] delay,
    // shadow copy of the line on the bus
    input  block_t expect_line,
    output logic store_error
);

    // 4 KB window, enough for every address the testbench uses
    logic [7:0] backing [4096];
    logic [mem_tag_bits-1:0] next_tag;

    // the cache never has more than one load in flight
    logic pending;
    logic [mem_tag_bits-1:0] pend_tag;
    block_t pend_data;
    int unsigned wait_cycles;

    function automatic block_t line_at(logic [11:0] addr);
        block_t blk;
        for (int b = 0; b < 8; b++) begin
            blk[8*b +: 8] = backing[{addr[11:3], 3'(b)}];
        end
        return blk;
    endfunction

    initial begin
        // power-up contents mix every address bit
        for (int i = 0; i < 4096; i++) begin
            backing[i] = 8'(i) ^ {4'(i >> 8), 4'(i >> 8)} ^ 8'h5a;
        end
        mem_accept_tag = '0;
        mem_resp_tag = '0;
        mem_rdata = '0;
        store_error = 1'b0;
        pending = 1'b0;
    end

    // drive the bus answers on the falling edge
    always @(negedge clock) begin
        if (reset || mem_cmd == bus_none || refuse) begin
            mem_accept_tag <= '0;
        end else begin
            mem_accept_tag <= next_tag;
        end
        if (!reset && pending && wait_cycles == 0) begin
            mem_resp_tag <= pend_tag;
            mem_rdata <= pend_data;
        end else begin
            mem_resp_tag <= '0;
            mem_rdata <= '0;
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            pending <= 1'b0;
            next_tag <= 4'd1;
        end else begin
            if (pending) begin
                // data went out this cycle
                if (mem_resp_tag != '0) begin
                    pending <= 1'b0;
                end else if (wait_cycles != 0) begin
                    wait_cycles <= wait_cycles - 1;
                end
            end
            if (mem_accept_tag != '0) begin
                // tags skip zero, which means no tag
                next_tag <= (next_tag == '1) ? 4'd1 : next_tag + 4'd1;
                if (mem_cmd == bus_store) begin
                    assert (mem_wdata == expect_line) else begin
                        $display("Mismatch at %0t: write-back of line %h is %h, shadow has %h",
                                 $time, mem_addr, mem_wdata, expect_line);
                        store_error <= 1'b1;
                    end
                    for (int b = 0; b < 8; b++) begin
                        backing[{mem_addr[11:3], 3'(b)}] <= mem_wdata[8*b +: 8];
                    end
                end else begin
                    pending <= 1'b1;
                    pend_tag <= mem_accept_tag;
                    pend_data <= line_at(mem_addr[11:0]);
                    wait_cycles <= 1 + delay;
                end
            end
        end
    end

endmodule

// File: dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic clock,
    input  logic reset,
    // pipeline request
    input  logic req_valid,
    input  mem_op_t req_op,
    input  logic [addr_width-1:0] req_addr,
    input  mem_size_t req_size,
    input  logic [31:0] req_wdata,
    output logic stall,
    // pipeline response
    output logic resp_valid,
    output mem_op_t resp_op,
    output logic [31:0] resp_rdata,
    // memory bus
    output bus_cmd_t mem_cmd,
    output logic [addr_width-1:0] mem_addr,
    output block_t mem_wdata,
    input  logic [mem_tag_bits-1:0] mem_accept_tag,
    input  logic [mem_tag_bits-1:0] mem_resp_tag,
    input  block_t mem_rdata
);

    // lookup results and controller state
    logic ready;
    logic main_hit;
    block_t main_block;
    logic vc_hit;
    block_t vc_block;

    // miss fill into the main cache
    logic fill_valid;
    line_addr_t fill_addr;
    block_t fill_block;
    logic fill_dirty;

    // main cache occupant displaced by a fill
    logic evict_valid;
    line_addr_t evict_addr;
    block_t evict_block;
    logic evict_dirty;

    // dirty line leaving the victim cache
    logic eject_valid;
    line_addr_t eject_addr;
    block_t eject_block;

    // bus requesters
    logic wb_valid;
    line_addr_t wb_addr;
    block_t wb_block;
    logic wb_grant;
    logic load_req;
    line_addr_t load_addr;
    logic load_grant;

    // all port names line up, so connect by name
    main_cache i_main_cache (.*);
    victim_cache i_victim_cache (.*);
    miss_control i_miss_control (.*);
    writeback_buffer i_writeback_buffer (.*);
    mem_arbiter i_mem_arbiter (.*);

endmodule

// File: mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import dcache_pkg::*; (
    input  logic wb_valid,
    input  line_addr_t wb_addr,
    input  block_t wb_block,
    output logic wb_grant,
    input  logic load_req,
    input  line_addr_t load_addr,
    output logic load_grant,
    output bus_cmd_t mem_cmd,
    output logic [addr_width-1:0] mem_addr,
    output block_t mem_wdata,
    input  logic [mem_tag_bits-1:0] mem_accept_tag
);

    logic accepted;

    // nonzero tag means memory took the request this cycle
    assign accepted = (mem_accept_tag != '0);

    always_comb begin
        mem_cmd = bus_none;
        mem_addr = '0;
        mem_wdata = '0;
        wb_grant = 1'b0;
        load_grant = 1'b0;
        if (wb_valid) begin
            // write-backs first, so a load never sees an older copy
            mem_cmd = bus_store;
            mem_addr = {wb_addr, {offset_bits{1'b0}}};
            mem_wdata = wb_block;
            wb_grant = accepted;
        end else if (load_req) begin
            mem_cmd = bus_load;
            mem_addr = {load_addr, {offset_bits{1'b0}}};
            load_grant = accepted;
        end
    end

endmodule

// File: writeback_buffer.sv
`timescale 1ns/1ps

module writeback_buffer import dcache_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic eject_valid,
    input  line_addr_t eject_addr,
    input  block_t eject_block,
    output logic wb_valid,
    output line_addr_t wb_addr,
    output block_t wb_block,
    input  logic wb_grant
);

    line_addr_t addr_q [wb_depth];
    block_t block_q [wb_depth];

    logic [$clog2(wb_depth)-1:0] rd_ptr;
    logic [$clog2(wb_depth)-1:0] wr_ptr;
    logic [$clog2(wb_depth):0] count;

    // head of the queue goes to the arbiter
    assign wb_valid = (count != '0);
    assign wb_addr = addr_q[rd_ptr];
    assign wb_block = block_q[rd_ptr];

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (eject_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // store is done once memory accepts it
            if (wb_grant) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({eject_valid, wb_grant})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (eject_valid) begin
            addr_q[wr_ptr] <= eject_addr;
            block_q[wr_ptr] <= eject_block;
        end
    end

endmodule

// File: miss_control.sv
`timescale 1ns/1ps

module miss_control import dcache_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic req_valid,
    input  mem_op_t req_op,
    input  logic [addr_width-1:0] req_addr,
    input  mem_size_t req_size,
    input  logic [31:0] req_wdata,
    input  logic main_hit,
    input  block_t main_block,
    input  logic vc_hit,
    input  block_t vc_block,
    output logic ready,
    output logic stall,
    output logic resp_valid,
    output mem_op_t resp_op,
    output logic [31:0] resp_rdata,
    output logic load_req,
    output line_addr_t load_addr,
    input  logic load_grant,
    input  logic [mem_tag_bits-1:0] mem_accept_tag,
    input  logic [mem_tag_bits-1:0] mem_resp_tag,
    input  block_t mem_rdata,
    output logic fill_valid,
    output line_addr_t fill_addr,
    output block_t fill_block,
    output logic fill_dirty
);

    typedef enum logic {
        st_ready = 1'b0,
        st_wait = 1'b1
    } state_t;

    state_t state;
    // load accepted by memory, waiting for its tag
    logic issued;
    logic [mem_tag_bits-1:0] pend_tag;

    // request held across the miss
    mem_op_t hold_op;
    logic [addr_width-1:0] hold_addr;
    mem_size_t hold_size;
    logic [31:0] hold_wdata;

    logic miss;
    logic fill_done;

    assign ready = (state == st_ready);
    assign stall = (state == st_wait);
    assign miss = ready && req_valid && !(main_hit || vc_hit);

    // keep asking until memory takes the load
    assign load_req = stall && !issued;
    assign load_addr = hold_addr[addr_width-1:offset_bits];

    // returning data for the one outstanding load
    assign fill_done = stall && issued && (mem_resp_tag == pend_tag);

    // store miss merges into the fresh line before install
    assign fill_valid = fill_done;
    assign fill_addr = load_addr;
    assign fill_dirty = (hold_op == op_write);
    assign fill_block = (hold_op == op_write)
        ? block_merge(mem_rdata, hold_addr[offset_bits-1:0], hold_size, hold_wdata)
        : mem_rdata;

    always_comb begin
        resp_valid = 1'b0;
        resp_op = op_read;
        resp_rdata = '0;
        if (fill_done) begin
            resp_valid = 1'b1;
            resp_op = hold_op;
            if (hold_op == op_read) begin
                resp_rdata = block_extract(mem_rdata, hold_addr[offset_bits-1:0], hold_size);
            end
        end else if (ready && req_valid && (main_hit || vc_hit)) begin
            // same-cycle hit, main cache first
            resp_valid = 1'b1;
            resp_op = req_op;
            if (req_op == op_read) begin
                resp_rdata = block_extract(main_hit ? main_block : vc_block,
                                           req_addr[offset_bits-1:0], req_size);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_ready;
            issued <= 1'b0;
        end else if (ready) begin
            if (miss) begin
                state <= st_wait;
                issued <= 1'b0;
            end
        end else begin
            if (load_grant) begin
                issued <= 1'b1;
            end
            if (fill_done) begin
                state <= st_ready;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (miss) begin
            hold_op <= req_op;
            hold_addr <= req_addr;
            hold_size <= req_size;
            hold_wdata <= req_wdata;
        end
        // tag that memory hands back for this load
        if (load_grant) begin
            pend_tag <= mem_accept_tag;
        end
    end

endmodule

// File: victim_cache.sv
`timescale 1ns/1ps

module victim_cache import dcache_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic req_valid,
    input  mem_op_t req_op,
    input  logic [addr_width-1:0] req_addr,
    input  mem_size_t req_size,
    input  logic [31:0] req_wdata,
    input  logic ready,
    output logic vc_hit,
    output block_t vc_block,
    input  logic evict_valid,
    input  line_addr_t evict_addr,
    input  block_t evict_block,
    input  logic evict_dirty,
    output logic eject_valid,
    output line_addr_t eject_addr,
    output block_t eject_block
);

    logic [n_victim-1:0] valid;
    logic [n_victim-1:0] dirty;
    logic [age_bits-1:0] ages [n_victim];
    line_addr_t addrs [n_victim];
    block_t blocks [n_victim];

    line_addr_t req_line;
    // one-hot entry selects
    logic [n_victim-1:0] hit_sel;
    logic [n_victim-1:0] free_sel;
    logic [n_victim-1:0] old_sel;
    logic [n_victim-1:0] ins_sel;
    logic [n_victim-1:0] touch_sel;
    logic have_free;
    logic [age_bits-1:0] min_age;
    logic store_hit;

    // fully associative, match on the whole line address
    assign req_line = req_addr[addr_width-1:offset_bits];

    always_comb begin
        vc_hit = 1'b0;
        vc_block = '0;
        hit_sel = '0;
        for (int i = 0; i < n_victim; i++) begin
            if (!vc_hit && req_valid && valid[i] && (addrs[i] == req_line)) begin
                vc_hit = 1'b1;
                vc_block = blocks[i];
                hit_sel[i] = 1'b1;
            end
        end
    end

    // first free entry, else lowest index among the lowest age
    always_comb begin
        free_sel = '0;
        have_free = 1'b0;
        for (int i = 0; i < n_victim; i++) begin
            if (!have_free && !valid[i]) begin
                have_free = 1'b1;
                free_sel[i] = 1'b1;
            end
        end
        min_age = ages[0];
        old_sel = '0;
        old_sel[0] = 1'b1;
        // strict compare keeps the lower index on a tie
        for (int i = 1; i < n_victim; i++) begin
            if (ages[i] < min_age) begin
                min_age = ages[i];
                old_sel = '0;
                old_sel[i] = 1'b1;
            end
        end
    end

    assign ins_sel = have_free ? free_sel : old_sel;
    assign store_hit = vc_hit && ready && (req_op == op_write);

    // hits and inserts age the same way
    assign touch_sel = (vc_hit && ready) ? hit_sel : (evict_valid ? ins_sel : '0);

    // only a dirty replaced line goes out, clean ones are dropped
    assign eject_valid = evict_valid && !have_free && |(old_sel & dirty);

    always_comb begin
        eject_addr = '0;
        eject_block = '0;
        for (int i = 0; i < n_victim; i++) begin
            if (old_sel[i]) begin
                eject_addr = addrs[i];
                eject_block = blocks[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
            ages <= '{default: '0};
        end else begin
            for (int i = 0; i < n_victim; i++) begin
                if (touch_sel[i]) begin
                    ages[i] <= '1;
                end else if (|touch_sel && ages[i] != '0) begin
                    ages[i] <= ages[i] - 1'b1;
                end
                if (evict_valid && ins_sel[i]) begin
                    valid[i] <= 1'b1;
                    dirty[i] <= evict_dirty;
                end else if (store_hit && hit_sel[i]) begin
                    dirty[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < n_victim; i++) begin
            if (evict_valid && ins_sel[i]) begin
                addrs[i] <= evict_addr;
                blocks[i] <= evict_block;
            end else if (store_hit && hit_sel[i]) begin
                blocks[i] <= block_merge(blocks[i], req_addr[offset_bits-1:0],
                                         req_size, req_wdata);
            end
        end
    end

endmodule

// File: main_cache.sv
`timescale 1ns/1ps

module main_cache import dcache_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic req_valid,
    input  mem_op_t req_op,
    input  logic [addr_width-1:0] req_addr,
    input  mem_size_t req_size,
    input  logic [31:0] req_wdata,
    input  logic ready,
    output logic main_hit,
    output block_t main_block,
    input  logic fill_valid,
    input  line_addr_t fill_addr,
    input  block_t fill_block,
    input  logic fill_dirty,
    output logic evict_valid,
    output line_addr_t evict_addr,
    output block_t evict_block,
    output logic evict_dirty
);

    // line state
    logic [n_lines-1:0] valid;
    logic [n_lines-1:0] dirty;
    // line contents
    logic [tag_bits-1:0] tags [n_lines];
    block_t blocks [n_lines];

    logic [index_bits-1:0] req_idx;
    logic [tag_bits-1:0] req_tag;
    logic [index_bits-1:0] fill_idx;
    logic store_hit;

    // direct mapped, one candidate line per index
    assign req_idx = req_addr[offset_bits +: index_bits];
    assign req_tag = req_addr[addr_width-1 -: tag_bits];
    assign main_hit = req_valid && valid[req_idx] && (tags[req_idx] == req_tag);
    assign main_block = blocks[req_idx];

    // stores only land while the controller is taking new requests
    assign store_hit = main_hit && ready && (req_op == op_write);

    // fill address carries the index in its low bits
    assign fill_idx = fill_addr[index_bits-1:0];

    // whatever sits at the fill index moves on to the victim cache
    assign evict_valid = fill_valid && valid[fill_idx];
    assign evict_addr = {tags[fill_idx], fill_idx};
    assign evict_block = blocks[fill_idx];
    assign evict_dirty = dirty[fill_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
        end else if (fill_valid) begin
            valid[fill_idx] <= 1'b1;
            // a store miss arrives already merged and dirty
            dirty[fill_idx] <= fill_dirty;
        end else if (store_hit) begin
            dirty[req_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_valid) begin
            tags[fill_idx] <= fill_addr[line_addr_bits-1 -: tag_bits];
            blocks[fill_idx] <= fill_block;
        end else if (store_hit) begin
            blocks[req_idx] <= block_merge(blocks[req_idx], req_addr[offset_bits-1:0],
                                           req_size, req_wdata);
        end
    end

endmodule

// File: dcache_pkg.sv
package dcache_pkg;

    // address and line geometry
    localparam int addr_width = 32;
    localparam int line_bytes = 8;
    localparam int offset_bits = 3;
    localparam int n_lines = 32;
    localparam int index_bits = 5;
    localparam int tag_bits = 24;
    localparam int line_addr_bits = 29;

    // victim cache and write-back buffer
    localparam int n_victim = 4;
    localparam int age_bits = 2;
    localparam int wb_depth = 2;

    // memory bus transaction tag, zero means no tag
    localparam int mem_tag_bits = 4;

    typedef logic [8*line_bytes-1:0] block_t;
    typedef logic [line_addr_bits-1:0] line_addr_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    typedef enum logic {
        op_read = 1'b0,
        op_write = 1'b1
    } mem_op_t;

    typedef enum logic [1:0] {
        bus_none = 2'd0,
        bus_load = 2'd1,
        bus_store = 2'd2
    } bus_cmd_t;

    // place store data into the lanes picked by size and offset
    // half and word accesses are assumed naturally aligned
    function automatic block_t block_merge(block_t blk, logic [offset_bits-1:0] offset,
                                           mem_size_t size, logic [31:0] data);
        block_t merged;
        merged = blk;
        case (size)
            size_byte: merged[8*offset +: 8] = data[7:0];
            size_half: merged[16*offset[offset_bits-1:1] +: 16] = data[15:0];
            default: merged[32*offset[offset_bits-1] +: 32] = data;
        endcase
        return merged;
    endfunction

    // zero-extended load value out of a line
    function automatic logic [31:0] block_extract(block_t blk, logic [offset_bits-1:0] offset,
                                                  mem_size_t size);
        logic [31:0] value;
        case (size)
            size_byte: value = {24'b0, blk[8*offset +: 8]};
            size_half: value = {16'b0, blk[16*offset[offset_bits-1:1] +: 16]};
            default: value = blk[32*offset[offset_bits-1] +: 32];
        endcase
        return value;
    endfunction

endpackage
